/* verilog/mipsPipe_config.svh */
`ifndef MIPS_PIPE_CONFIG_SVH
`define MIPS_PIPE_CONFIG_SVH

// Datapath and instruction word width
`define MIPS_XLEN       32

// Register file address width, 32 entries
`define MIPS_REG_AW     5

// Word-address widths of the two memories
`define MIPS_IMEM_AW    8
`define MIPS_DMEM_AW    8

// Immediate, opcode and funct field widths
`define MIPS_IMM_W      16
`define MIPS_OPC_W      6

// Instruction field positions (lsb of each field)
`define MIPS_OPC_LSB    26
`define MIPS_RS_LSB     21
`define MIPS_RT_LSB     16
`define MIPS_RD_LSB     11
`define MIPS_FUNCT_LSB  0
`define MIPS_IMM_LSB    0

// Byte offset bits of a word address
`define MIPS_WORD_OFS   2

`endif

/* verilog/mipsPkg.sv */
`default_nettype none

`include "mipsPipe_config.svh"

package mipsPkg;

    // Major opcodes, bits 31:26
    typedef enum logic [`MIPS_OPC_W-1:0] {
        OPC_RTYPE = 6'h00,
        OPC_BEQ   = 6'h04,
        OPC_ADDI  = 6'h08,
        OPC_LW    = 6'h23,
        OPC_SW    = 6'h2B
    } opcodeE;

    // R-type funct codes, bits 5:0
    typedef enum logic [`MIPS_OPC_W-1:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } functE;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpE;

    // Coarse class out of decode, refined by funct in execute
    typedef enum logic [1:0] {
        CLS_MEM    = 2'd0,
        CLS_BRANCH = 2'd1,
        CLS_RTYPE  = 2'd2
    } aluSrcClassE;

    typedef struct packed {
        logic        regWrite;
        logic        memToReg;
        logic        branch;
        logic        memRead;
        logic        memWrite;
        logic        aluSrcImm;
        logic        regDst;
        aluSrcClassE cls;
    } ctrlS;

endpackage

`default_nettype wire

/* verilog/stageIf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsPipe_config.svh"

////////////////////////////////////////////////////////////////////////////
// IF/ID
////////////////////////////////////////////////////////////////////////////
interface ifIdIf;
    logic [`MIPS_XLEN-1:0] pcPlus4;
    logic [`MIPS_XLEN-1:0] instruction;

    modport producer (output pcPlus4, output instruction);
    modport consumer (input pcPlus4, input instruction);
endinterface

////////////////////////////////////////////////////////////////////////////
// ID/EX
////////////////////////////////////////////////////////////////////////////
interface idExIf;
    logic [`MIPS_XLEN-1:0]   pcPlus4;
    mipsPkg::ctrlS           ctrl;
    logic [`MIPS_XLEN-1:0]   readData1;
    logic [`MIPS_XLEN-1:0]   readData2;
    logic [`MIPS_XLEN-1:0]   immExt;
    logic [`MIPS_REG_AW-1:0] rt;
    logic [`MIPS_REG_AW-1:0] rd;
    logic [`MIPS_OPC_W-1:0]  funct;

    modport producer (output pcPlus4, output ctrl, output readData1, output readData2,
                      output immExt, output rt, output rd, output funct);
    modport consumer (input pcPlus4, input ctrl, input readData1, input readData2,
                      input immExt, input rt, input rd, input funct);
endinterface

////////////////////////////////////////////////////////////////////////////
// EX/MEM
////////////////////////////////////////////////////////////////////////////
interface exMemIf;
    mipsPkg::ctrlS           ctrl;
    logic [`MIPS_XLEN-1:0]   branchTarget;
    logic                    zero;
    logic [`MIPS_XLEN-1:0]   aluResult;
    logic [`MIPS_XLEN-1:0]   storeData;
    logic [`MIPS_REG_AW-1:0] destReg;

    modport producer (output ctrl, output branchTarget, output zero, output aluResult,
                      output storeData, output destReg);
    modport consumer (input ctrl, input branchTarget, input zero, input aluResult,
                      input storeData, input destReg);
endinterface

////////////////////////////////////////////////////////////////////////////
// MEM/WB
////////////////////////////////////////////////////////////////////////////
interface memWbIf;
    logic                    regWrite;
    logic                    memToReg;
    logic [`MIPS_XLEN-1:0]   aluResult;
    logic [`MIPS_XLEN-1:0]   loadData;
    logic [`MIPS_REG_AW-1:0] destReg;

    modport producer (output regWrite, output memToReg, output aluResult,
                      output loadData, output destReg);
    modport consumer (input regWrite, input memToReg, input aluResult,
                      input loadData, input destReg);
endinterface

`default_nettype wire

/* verilog/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsPipe_config.svh"

module fetchStage (
    input  wire                     i_clk,
    input  wire                     i_arstN,
    input  wire                     i_imemWe,
    input  wire [`MIPS_IMEM_AW-1:0] i_imemAddr,
    input  wire [`MIPS_XLEN-1:0]    i_imemData,
    input  wire                     i_branchTaken,
    input  wire [`MIPS_XLEN-1:0]    i_branchTarget,
    ifIdIf.producer                 ifId
);

    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pcPlus4;
    logic [`MIPS_XLEN-1:0] nextPc;
    logic [`MIPS_XLEN-1:0] instr;

    logic [`MIPS_XLEN-1:0] instrMem [0:(1 << `MIPS_IMEM_AW)-1];

    // Loader port, only driven while the core sits in reset
    always_ff @(posedge i_clk) begin
        if (i_imemWe) begin
            instrMem[i_imemAddr] <= i_imemData;
        end
    end

    // Asynchronous read, word addressed
    assign instr   = instrMem[pc[`MIPS_IMEM_AW+`MIPS_WORD_OFS-1:`MIPS_WORD_OFS]];
    assign pcPlus4 = pc + `MIPS_XLEN'd4;

    // Taken beq from MEM overrides sequential fetch
    assign nextPc = i_branchTaken ? i_branchTarget : pcPlus4;

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            pc               <= '0;
            ifId.instruction <= '0;
        end else begin
            pc               <= nextPc;
            ifId.instruction <= instr;
        end
    end

    always_ff @(posedge i_clk) begin
        ifId.pcPlus4 <= pcPlus4;
    end

    // Branch targets come from execute, so this covers the whole loop
    pcAligned: assert property (@(posedge i_clk) disable iff (!i_arstN)
        pc[`MIPS_WORD_OFS-1:0] == '0);

endmodule

`default_nettype wire

/* verilog/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsPipe_config.svh"

module decodeStage (
    input  wire                      i_clk,
    input  wire                      i_arstN,
    ifIdIf.consumer                  ifId,
    idExIf.producer                  idEx,
    memWbIf.consumer                 memWb,
    output logic                     o_wbValid,
    output logic [`MIPS_REG_AW-1:0]  o_wbReg,
    output logic [`MIPS_XLEN-1:0]    o_wbData
);

    logic [`MIPS_OPC_W-1:0]  opcode;
    logic [`MIPS_OPC_W-1:0]  funct;
    logic [`MIPS_REG_AW-1:0] rs;
    logic [`MIPS_REG_AW-1:0] rt;
    logic [`MIPS_REG_AW-1:0] rd;
    logic [`MIPS_IMM_W-1:0]  imm;
    logic                    functOk;
    mipsPkg::ctrlS           ctrl;
    logic [`MIPS_XLEN-1:0]   wbData;
    logic                    wbValid;

    logic [`MIPS_XLEN-1:0] regFile [0:(1 << `MIPS_REG_AW)-1];

    // Field split
    assign opcode = ifId.instruction[`MIPS_OPC_LSB +: `MIPS_OPC_W];
    assign rs     = ifId.instruction[`MIPS_RS_LSB +: `MIPS_REG_AW];
    assign rt     = ifId.instruction[`MIPS_RT_LSB +: `MIPS_REG_AW];
    assign rd     = ifId.instruction[`MIPS_RD_LSB +: `MIPS_REG_AW];
    assign funct  = ifId.instruction[`MIPS_FUNCT_LSB +: `MIPS_OPC_W];
    assign imm    = ifId.instruction[`MIPS_IMM_LSB +: `MIPS_IMM_W];

    // All-zero word (sll nop) lands here as an unsupported funct
    assign functOk = funct inside {mipsPkg::FN_ADD, mipsPkg::FN_SUB, mipsPkg::FN_AND,
                                   mipsPkg::FN_OR, mipsPkg::FN_SLT};

    ////////////////////////////////////////////////////////////////////////////
    // Main control
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        ctrl = '0;
        case (mipsPkg::opcodeE'(opcode))
            mipsPkg::OPC_RTYPE: begin
                if (functOk) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDst   = 1'b1;
                    ctrl.cls      = mipsPkg::CLS_RTYPE;
                end
            end
            mipsPkg::OPC_ADDI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            mipsPkg::OPC_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            mipsPkg::OPC_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            mipsPkg::OPC_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.cls    = mipsPkg::CLS_BRANCH;
            end
            default: ctrl = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write-back and register file
    ////////////////////////////////////////////////////////////////////////////
    assign wbData  = memWb.memToReg ? memWb.loadData : memWb.aluResult;
    assign wbValid = memWb.regWrite && (memWb.destReg != '0);

    assign o_wbValid = wbValid;
    assign o_wbReg   = memWb.destReg;
    assign o_wbData  = wbData;

    // $zero holds zero and is never written
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            regFile[0] <= '0;
        end else if (wbValid) begin
            regFile[memWb.destReg] <= wbData;
        end
    end

    // ID/EX control clears to a bubble on reset
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            idEx.ctrl <= '0;
        end else begin
            idEx.ctrl <= ctrl;
        end
    end

    // Reads see the old value on a same-cycle write
    always_ff @(posedge i_clk) begin
        idEx.pcPlus4   <= ifId.pcPlus4;
        idEx.readData1 <= regFile[rs];
        idEx.readData2 <= regFile[rt];
        idEx.immExt    <= {{(`MIPS_XLEN-`MIPS_IMM_W){imm[`MIPS_IMM_W-1]}}, imm};
        idEx.rt        <= rt;
        idEx.rd        <= rd;
        idEx.funct     <= funct;
    end

    rsZeroReads: assert property (@(posedge i_clk) disable iff (!i_arstN)
        (rs == '0) |=> (idEx.readData1 == '0));

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsPipe_config.svh"

module executeStage (
    input  wire      i_clk,
    input  wire      i_arstN,
    idExIf.consumer  idEx,
    exMemIf.producer exMem
);

    mipsPkg::aluOpE          aluOp;
    logic [`MIPS_XLEN-1:0]   operandB;
    logic [`MIPS_XLEN-1:0]   aluResult;
    logic                    zero;
    logic [`MIPS_XLEN-1:0]   branchTarget;
    logic [`MIPS_REG_AW-1:0] destReg;

    ////////////////////////////////////////////////////////////////////////////
    // ALU control
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        aluOp = mipsPkg::ALU_ADD;
        case (idEx.ctrl.cls)
            mipsPkg::CLS_BRANCH: aluOp = mipsPkg::ALU_SUB;
            mipsPkg::CLS_RTYPE: begin
                case (mipsPkg::functE'(idEx.funct))
                    mipsPkg::FN_ADD: aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUB: aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND: aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:  aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_SLT: aluOp = mipsPkg::ALU_SLT;
                    default:         aluOp = mipsPkg::ALU_ADD;
                endcase
            end
            // lw, sw and addi all add
            default: aluOp = mipsPkg::ALU_ADD;
        endcase
    end

    assign operandB = idEx.ctrl.aluSrcImm ? idEx.immExt : idEx.readData2;

    always_comb begin
        case (aluOp)
            mipsPkg::ALU_SUB: aluResult = idEx.readData1 - operandB;
            mipsPkg::ALU_AND: aluResult = idEx.readData1 & operandB;
            mipsPkg::ALU_OR:  aluResult = idEx.readData1 | operandB;
            mipsPkg::ALU_SLT: begin
                aluResult = {{(`MIPS_XLEN-1){1'b0}},
                             $signed(idEx.readData1) < $signed(operandB)};
            end
            default:          aluResult = idEx.readData1 + operandB;
        endcase
    end

    assign zero = (aluResult == '0);

    // Target relative to the delay-slot address
    assign branchTarget = idEx.pcPlus4 + (idEx.immExt << `MIPS_WORD_OFS);

    assign destReg = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

    ////////////////////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            exMem.ctrl <= '0;
        end else begin
            exMem.ctrl <= idEx.ctrl;
        end
    end

    always_ff @(posedge i_clk) begin
        exMem.branchTarget <= branchTarget;
        exMem.zero         <= zero;
        exMem.aluResult    <= aluResult;
        exMem.storeData    <= idEx.readData2;
        exMem.destReg      <= destReg;
    end

    // Decode should have turned unsupported functs into bubbles
    rtypeFunctKnown: assert property (@(posedge i_clk) disable iff (!i_arstN)
        (idEx.ctrl.cls == mipsPkg::CLS_RTYPE) |->
        (idEx.funct inside {mipsPkg::FN_ADD, mipsPkg::FN_SUB, mipsPkg::FN_AND,
                            mipsPkg::FN_OR, mipsPkg::FN_SLT}));

endmodule

`default_nettype wire

/* verilog/memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsPipe_config.svh"

module memoryStage (
    input  wire                   i_clk,
    input  wire                   i_arstN,
    exMemIf.consumer              exMem,
    memWbIf.producer              memWb,
    output logic                  o_branchTaken,
    output logic [`MIPS_XLEN-1:0] o_branchTarget
);

    logic [`MIPS_DMEM_AW-1:0] dmemAddr;
    logic [`MIPS_XLEN-1:0]    loadData;

    logic [`MIPS_XLEN-1:0] dataMem [0:(1 << `MIPS_DMEM_AW)-1];

    // aluResult is taken as a word index
    assign dmemAddr = exMem.aluResult[`MIPS_DMEM_AW-1:0];

    always_ff @(posedge i_clk) begin
        if (exMem.ctrl.memWrite) begin
            dataMem[dmemAddr] <= exMem.storeData;
        end
    end

    assign loadData = exMem.ctrl.memRead ? dataMem[dmemAddr] : '0;

    // beq resolves here, PC picks it up on the next edge
    assign o_branchTaken  = exMem.ctrl.branch && exMem.zero;
    assign o_branchTarget = exMem.branchTarget;

    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            memWb.regWrite <= 1'b0;
            memWb.memToReg <= 1'b0;
        end else begin
            memWb.regWrite <= exMem.ctrl.regWrite;
            memWb.memToReg <= exMem.ctrl.memToReg;
        end
    end

    always_ff @(posedge i_clk) begin
        memWb.aluResult <= exMem.aluResult;
        memWb.loadData  <= loadData;
        memWb.destReg   <= exMem.destReg;
    end

    memRdWrExclusive: assert property (@(posedge i_clk) disable iff (!i_arstN)
        !(exMem.ctrl.memRead && exMem.ctrl.memWrite));

endmodule

`default_nettype wire

/* verilog/mipsPipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsPipe_config.svh"

module mipsPipe (
    input  wire                      i_clk,
    input  wire                      i_arstN,
    input  wire                      i_imemWe,
    input  wire [`MIPS_IMEM_AW-1:0]  i_imemAddr,
    input  wire [`MIPS_XLEN-1:0]     i_imemData,
    output logic                     o_wbValid,
    output logic [`MIPS_REG_AW-1:0]  o_wbReg,
    output logic [`MIPS_XLEN-1:0]    o_wbData
);

    // Branch feedback from MEM to IF
    logic                  branchTaken;
    logic [`MIPS_XLEN-1:0] branchTarget;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////////////////////
    ifIdIf  ifIdBus ();
    idExIf  idExBus ();
    exMemIf exMemBus ();
    memWbIf memWbBus ();

    ////////////////////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////////////////////
    fetchStage u_fetchStage (
        .i_clk          (i_clk),
        .i_arstN        (i_arstN),
        .i_imemWe       (i_imemWe),
        .i_imemAddr     (i_imemAddr),
        .i_imemData     (i_imemData),
        .i_branchTaken  (branchTaken),
        .i_branchTarget (branchTarget),
        .ifId           (ifIdBus.producer)
    );

    // Decode also hosts write-back
    decodeStage u_decodeStage (
        .i_clk     (i_clk),
        .i_arstN   (i_arstN),
        .ifId      (ifIdBus.consumer),
        .idEx      (idExBus.producer),
        .memWb     (memWbBus.consumer),
        .o_wbValid (o_wbValid),
        .o_wbReg   (o_wbReg),
        .o_wbData  (o_wbData)
    );

    executeStage u_executeStage (
        .i_clk   (i_clk),
        .i_arstN (i_arstN),
        .idEx    (idExBus.consumer),
        .exMem   (exMemBus.producer)
    );

    memoryStage u_memoryStage (
        .i_clk          (i_clk),
        .i_arstN        (i_arstN),
        .exMem          (exMemBus.consumer),
        .memWb          (memWbBus.producer),
        .o_branchTaken  (branchTaken),
        .o_branchTarget (branchTarget)
    );

endmodule

`default_nettype wire

/* tb/mipsRefModel.svh */
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Program building
////////////////////////////////////////////////////////////////////////////

// LCG step, upper half makes the better immediate
function automatic logic [15:0] randImm();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];
endfunction

function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rd,
                                     input logic [4:0] rs, input logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
                                     input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// Three nops after every word, the core has no interlocks
task automatic emit(input logic [31:0] word);
    prog[progLen] = word;
    for (int i = 1; i <= 3; i++) begin
        prog[progLen + i] = 32'h0;
    end
    progLen += 4;
endtask

////////////////////////////////////////////////////////////////////////////
// Architectural model, beq has three delay slots
////////////////////////////////////////////////////////////////////////////
task automatic predictWrites();
    int          pc;
    int          n;
    int          slots;
    int          pend;
    int          off;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] ea;
    logic [31:0] val;
    logic [4:0]  dst;
    logic        wr;
    logic        taken;
    pc = 0;
    n = 0;
    slots = 0;
    pend = 0;
    expCount = 0;
    runLen = 0;
    while (runLen == 0 && n < 2000) begin
        w = prog[pc];
        a = (w[25:21] == 5'd0) ? 32'd0 : refReg[w[25:21]];
        b = (w[20:16] == 5'd0) ? 32'd0 : refReg[w[20:16]];
        imm = {{16{w[15]}}, w[15:0]};
        off = $signed(imm);
        ea = a + imm;
        dst = w[20:16];
        val = 32'd0;
        wr = 1'b0;
        taken = 1'b0;
        case (w[31:26])
            mipsPkg::OPC_RTYPE: begin
                wr = 1'b1;
                dst = w[15:11];
                case (w[5:0])
                    mipsPkg::FN_ADD: val = a + b;
                    mipsPkg::FN_SUB: val = a - b;
                    mipsPkg::FN_AND: val = a & b;
                    mipsPkg::FN_OR:  val = a | b;
                    mipsPkg::FN_SLT: val = {31'd0, $signed(a) < $signed(b)};
                    default:         wr = 1'b0;
                endcase
            end
            mipsPkg::OPC_ADDI: begin
                wr = 1'b1;
                val = ea;
            end
            mipsPkg::OPC_LW: begin
                wr = 1'b1;
                val = refMem[ea[7:0]];
            end
            mipsPkg::OPC_SW:  refMem[ea[7:0]] = b;
            mipsPkg::OPC_BEQ: taken = (a == b);
            default: ;
        endcase
        // Fetched in cycle n, seen on the write-back port in cycle n+4
        if (wr && dst != 5'd0) begin
            refReg[dst] = val;
            expCycleArr[expCount] = n + 4;
            expRegArr[expCount] = dst;
            expDataArr[expCount] = val;
            expCount++;
        end
        if (taken && off == -1) begin
            runLen = n + 8;
        end else if (taken) begin
            slots = 3;
            pend = pc + 1 + off;
            pc++;
        end else if (slots > 0) begin
            slots--;
            pc = (slots == 0) ? pend : pc + 1;
        end else begin
            pc++;
        end
        n++;
    end
    if (runLen == 0) begin
        runLen = n + 8;
    end
endtask

`endif

/* tb/mipsPipeTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mipsPipe_config.svh"

module mipsPipeTb;

    logic                     i_clk;
    logic                     i_arstN;
    logic                     i_imemWe;
    logic [`MIPS_IMEM_AW-1:0] i_imemAddr;
    logic [`MIPS_XLEN-1:0]    i_imemData;
    logic                     o_wbValid;
    logic [`MIPS_REG_AW-1:0]  o_wbReg;
    logic [`MIPS_XLEN-1:0]    o_wbData;

    // Program image and model state
    logic [31:0] prog [0:255];
    logic [31:0] refReg [0:31];
    logic [31:0] refMem [0:255];
    logic [31:0] lcgState;
    int          progLen;

    // Expected write-backs in program order, with their cycle
    int          expCycleArr [0:255];
    logic [4:0]  expRegArr [0:255];
    logic [31:0] expDataArr [0:255];
    int          expCount;
    int          expIdx;
    int          runLen;
    int          runCycle;
    logic        running;
    logic        headValid;
    int          headCycle;
    logic [4:0]  headReg;
    logic [31:0] headData;

    int errCount;
    int testCount;
    int wbTotal;
    int cycleCount;
    int cycleLimit = 20;

    `include "mipsRefModel.svh"

    mipsPipe u_dut (
        .i_clk      (i_clk),
        .i_arstN    (i_arstN),
        .i_imemWe   (i_imemWe),
        .i_imemAddr (i_imemAddr),
        .i_imemData (i_imemData),
        .o_wbValid  (o_wbValid),
        .o_wbReg    (o_wbReg),
        .o_wbData   (o_wbData)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    assign headValid = (expIdx < expCount);
    assign headCycle = expCycleArr[expIdx];
    assign headReg   = expRegArr[expIdx];
    assign headData  = expDataArr[expIdx];

    // Cycle count since release, head moves on once its cycle has passed
    always @(posedge i_clk) begin
        if (!running) begin
            runCycle <= 0;
            expIdx   <= 0;
        end else begin
            runCycle <= runCycle + 1;
            if (headValid && runCycle >= headCycle) begin
                expIdx <= expIdx + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write-back checks
    ////////////////////////////////////////////////////////////////////////////
    wbOnSchedule: assert property (@(posedge i_clk) disable iff (!running)
        o_wbValid |-> (headValid && runCycle == headCycle))
        else begin
            errCount++;
            $display("Unexpected write-back to r%0d at %0t in cycle %0d",
                     $sampled(o_wbReg), $time, $sampled(runCycle));
        end

    wbNotMissed: assert property (@(posedge i_clk) disable iff (!running)
        (headValid && runCycle == headCycle) |-> o_wbValid)
        else begin
            errCount++;
            $display("Write-back to r%0d missing at %0t, due in cycle %0d",
                     $sampled(headReg), $time, $sampled(headCycle));
        end

    wbRegMatch: assert property (@(posedge i_clk) disable iff (!running)
        (o_wbValid && headValid && runCycle == headCycle) |-> (o_wbReg == headReg))
        else begin
            errCount++;
            $display("FAILED at %0t: o_wbReg = %0d, expected %0d",
                     $time, $sampled(o_wbReg), $sampled(headReg));
        end

    wbDataMatch: assert property (@(posedge i_clk) disable iff (!running)
        (o_wbValid && headValid && runCycle == headCycle) |-> (o_wbData == headData))
        else begin
            errCount++;
            $display("FAILED at %0t: o_wbData = %h, expected %h",
                     $time, $sampled(o_wbData), $sampled(headData));
        end

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////////////////////

    // Load under reset, release, run until the model's last write has drained
    task automatic runProgram(input string name);
        int errBefore;
        int holdLen;
        errBefore = errCount;
        // Park on a self-loop so stale words never execute
        emit(encI(mipsPkg::OPC_BEQ, 5'd0, 5'd0, 16'hFFFF));
        predictWrites();
        cycleLimit += progLen + runLen + 16;
        holdLen = (progLen > 16) ? progLen : 16;
        @(negedge i_clk);
        running = 1'b0;
        i_arstN = 1'b0;
        for (int i = 0; i < holdLen; i++) begin
            i_imemWe   = (i < progLen);
            i_imemAddr = 8'(i);
            i_imemData = prog[i];
            @(negedge i_clk);
        end
        i_imemWe = 1'b0;
        i_arstN  = 1'b1;
        running  = 1'b1;
        while (runCycle < runLen) begin
            @(negedge i_clk);
        end
        running = 1'b0;
        assert (expIdx == expCount) else begin
            errCount++;
            $display("Test %s saw %0d of %0d write-backs", name, expIdx, expCount);
        end
        testCount++;
        wbTotal += expCount;
        $display("Test %0d (%s): %0d write-backs, %0d errors",
                 testCount, name, expCount, errCount - errBefore);
    endtask

    task automatic resetTiming();
        progLen = 0;
        emit(32'h0);
        emit(encI(mipsPkg::OPC_ADDI, 5'd1, 5'd0, randImm()));
        emit(encI(mipsPkg::OPC_ADDI, 5'd2, 5'd0, randImm()));
        runProgram("reset timing");
    endtask

    task automatic aluMix();
        progLen = 0;
        emit(encI(mipsPkg::OPC_ADDI, 5'd1, 5'd0, randImm()));
        emit(encI(mipsPkg::OPC_ADDI, 5'd2, 5'd0, randImm()));
        emit(encR(mipsPkg::FN_ADD, 5'd3, 5'd1, 5'd2));
        emit(encR(mipsPkg::FN_SUB, 5'd4, 5'd1, 5'd2));
        emit(encR(mipsPkg::FN_AND, 5'd5, 5'd1, 5'd2));
        emit(encR(mipsPkg::FN_OR, 5'd6, 5'd1, 5'd2));
        emit(encR(mipsPkg::FN_SLT, 5'd7, 5'd1, 5'd2));
        emit(encR(mipsPkg::FN_SLT, 5'd8, 5'd2, 5'd1));
        runProgram("alu ops");
    endtask

    task automatic loadStore();
        progLen = 0;
        emit(encI(mipsPkg::OPC_ADDI, 5'd10, 5'd0, randImm() & 16'h007F));
        emit(encI(mipsPkg::OPC_ADDI, 5'd11, 5'd0, randImm()));
        emit(encI(mipsPkg::OPC_ADDI, 5'd12, 5'd0, randImm()));
        emit(encI(mipsPkg::OPC_SW, 5'd11, 5'd10, 16'd0));
        emit(encI(mipsPkg::OPC_SW, 5'd12, 5'd10, 16'd1));
        emit(encI(mipsPkg::OPC_LW, 5'd13, 5'd10, 16'd0));
        emit(encI(mipsPkg::OPC_LW, 5'd14, 5'd10, 16'd1));
        runProgram("load store");
    endtask

    // Target sits past one skipped instruction, offset 7 words from the slot
    task automatic branchSkip();
        logic [15:0] v;
        v = randImm();
        progLen = 0;
        emit(encI(mipsPkg::OPC_ADDI, 5'd1, 5'd0, v));
        emit(encI(mipsPkg::OPC_ADDI, 5'd2, 5'd0, v));
        emit(encI(mipsPkg::OPC_ADDI, 5'd3, 5'd0, v ^ 16'h0001));
        emit(encI(mipsPkg::OPC_BEQ, 5'd2, 5'd1, 16'd7));
        emit(encI(mipsPkg::OPC_ADDI, 5'd5, 5'd0, randImm()));
        emit(encI(mipsPkg::OPC_ADDI, 5'd6, 5'd0, randImm()));
        emit(encI(mipsPkg::OPC_BEQ, 5'd3, 5'd1, 16'd7));
        emit(encI(mipsPkg::OPC_ADDI, 5'd7, 5'd0, randImm()));
        emit(encI(mipsPkg::OPC_ADDI, 5'd8, 5'd0, randImm()));
        runProgram("branch");
    endtask

    task automatic zeroRegister();
        progLen = 0;
        emit(encI(mipsPkg::OPC_ADDI, 5'd0, 5'd0, randImm()));
        emit(encI(mipsPkg::OPC_ADDI, 5'd9, 5'd0, randImm()));
        emit(encR(mipsPkg::FN_ADD, 5'd0, 5'd9, 5'd9));
        emit(encR(mipsPkg::FN_ADD, 5'd15, 5'd0, 5'd9));
        emit(encR(mipsPkg::FN_OR, 5'd16, 5'd9, 5'd0));
        runProgram("register zero");
    endtask

    initial begin
        i_arstN    = 1'b0;
        i_imemWe   = 1'b0;
        i_imemAddr = '0;
        i_imemData = '0;
        running    = 1'b0;
        expCount   = 0;
        errCount   = 0;
        testCount  = 0;
        wbTotal    = 0;
        lcgState   = 32'h8482076d;
        refReg[0]  = '0;
        resetTiming();
        aluMix();
        loadStore();
        branchSkip();
        zeroRegister();
        $display("Summary: %0d tests, %0d write-backs checked, %0d errors",
                 testCount, wbTotal, errCount);
        if (errCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Limit grows as each test adds its load and run length
    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge i_clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the tests did not complete", cycleCount);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* mipsPipe.f */
+incdir+verilog
+incdir+tb
verilog/mipsPkg.sv
verilog/stageIf.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsPipe.sv
tb/mipsPipeTb.sv
